//--- hw/dts_rx_config.svh
`ifndef DTS_RX_CONFIG_SVH
`define DTS_RX_CONFIG_SVH

// Lane structure
`define DTS_N_LANES     4
`define DTS_WORD_W      18   // 2-bit header + payload
`define DTS_PAYLOAD_W   16
`define DTS_SEL_W       2    // Physical lane number

// Word boundary search
`define DTS_LOCK_GOOD   16   // Valid headers in a row to lock
`define DTS_LOSS_BAD    4    // Bad headers in a row to drop lock
`define DTS_HOLDOFF     32   // Settle time after a gearbox slip

// Lane alignment
`define DTS_MAX_OFFSET  7
`define DTS_OFS_W       3

// Header codes
`define DTS_HDR_DATA    2'b10
`define DTS_HDR_CTRL    2'b01

`endif

//--- hw/dts_rx_pkg.sv
`include "dts_rx_config.svh"

package dts_rx_pkg;

  ///////////////////////////////
  // Plain vectors
  ///////////////////////////////

  typedef logic [`DTS_WORD_W-1:0]    lane_word_t;  // Raw gearbox word
  typedef logic [`DTS_PAYLOAD_W-1:0] payload_t;
  typedef logic [`DTS_SEL_W-1:0]     lane_sel_t;   // Physical lane select

  ///////////////////////////////
  // Frame between stages
  ///////////////////////////////

  // Declared MSB first, so index lands on bit 0 as in the control word
  typedef struct packed {
    logic sync;
    logic ten_sec;
    logic one_sec;
    logic index;
  } markers_t;

  typedef struct packed {
    logic     vld;   // Data word present
    markers_t mark;  // Only on control words
    payload_t data;
  } dts_frame_t;

  // Word boundary search
  typedef enum logic [1:0] {
    HUNT,
    HOLDOFF,
    LOCKED
  } def_state_e;

endpackage

//--- hw/dts_lane_deformatter.sv
`timescale 1ns/1ps
`include "dts_rx_config.svh"

module dts_lane_deformatter (
  input  logic                   gt_clkout,
  input  logic                   arst_n_i,
  input  dts_rx_pkg::lane_word_t word_i,
  input  logic                   word_vld_i,
  output logic                   slip_o,
  output logic                   locked_o,
  output dts_rx_pkg::dts_frame_t frame_o
);

  // One counter serves both the good run in HUNT and the bad run in LOCKED
  localparam int HDR_CNT_MAX = (`DTS_LOCK_GOOD > `DTS_LOSS_BAD) ? `DTS_LOCK_GOOD
                                                                : `DTS_LOSS_BAD;
  localparam int HDR_CNT_W   = $clog2(HDR_CNT_MAX + 1);
  localparam int HOLD_CNT_W  = $clog2(`DTS_HOLDOFF + 1);

  localparam logic [HDR_CNT_W-1:0]  GOOD_LAST = HDR_CNT_W'(`DTS_LOCK_GOOD - 1);
  localparam logic [HDR_CNT_W-1:0]  BAD_LAST  = HDR_CNT_W'(`DTS_LOSS_BAD - 1);
  localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(`DTS_HOLDOFF - 1);

  dts_rx_pkg::def_state_e state_q;
  logic [HDR_CNT_W-1:0]   hdr_cnt_q;
  logic [HOLD_CNT_W-1:0]  hold_cnt_q;
  logic [1:0]             hdr;
  logic                   is_data;
  logic                   is_ctrl;
  logic                   hdr_ok;
  dts_rx_pkg::payload_t   payload;

  assign hdr     = word_i[`DTS_WORD_W-1 -: 2];
  assign payload = word_i[`DTS_PAYLOAD_W-1:0];
  assign is_data = (hdr == `DTS_HDR_DATA);
  assign is_ctrl = (hdr == `DTS_HDR_CTRL);
  assign hdr_ok  = is_data | is_ctrl;  // 00 and 11 never occur on a good boundary

  assign locked_o = (state_q == dts_rx_pkg::LOCKED);

  ///////////////////////////////
  // Lock FSM
  ///////////////////////////////

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= dts_rx_pkg::HUNT;
      hdr_cnt_q  <= '0;
      hold_cnt_q <= '0;
      slip_o     <= 1'b0;
    end else begin
      slip_o <= 1'b0;  // Single-cycle request
      case (state_q)
        dts_rx_pkg::HUNT: begin
          if (word_vld_i) begin
            if (!hdr_ok) begin
              slip_o     <= 1'b1;
              state_q    <= dts_rx_pkg::HOLDOFF;
              hold_cnt_q <= '0;
              hdr_cnt_q  <= '0;
            end else if (hdr_cnt_q == GOOD_LAST) begin
              state_q   <= dts_rx_pkg::LOCKED;
              hdr_cnt_q <= '0;
            end else begin
              hdr_cnt_q <= hdr_cnt_q + 1'b1;
            end
          end
        end
        dts_rx_pkg::HOLDOFF: begin
          // Gearbox output is garbage for a while, counts cycles not words
          if (hold_cnt_q == HOLD_LAST) begin
            state_q   <= dts_rx_pkg::HUNT;
            hdr_cnt_q <= '0;
          end
          hold_cnt_q <= hold_cnt_q + 1'b1;
        end
        dts_rx_pkg::LOCKED: begin
          if (word_vld_i) begin
            if (hdr_ok) begin
              hdr_cnt_q <= '0;  // Bad run broken
            end else if (hdr_cnt_q == BAD_LAST) begin
              state_q   <= dts_rx_pkg::HUNT;
              hdr_cnt_q <= '0;
            end else begin
              hdr_cnt_q <= hdr_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= dts_rx_pkg::HUNT;
      endcase
    end
  end

  ///////////////////////////////
  // Frame extraction
  ///////////////////////////////

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_o <= '0;
    end else begin
      frame_o <= '0;
      if (word_vld_i && (state_q == dts_rx_pkg::LOCKED)) begin
        if (is_data) begin
          frame_o.vld  <= 1'b1;
          frame_o.data <= payload;
        end else if (is_ctrl) begin
          frame_o.mark.index   <= payload[0];
          frame_o.mark.one_sec <= payload[1];
          frame_o.mark.ten_sec <= payload[2];
          frame_o.mark.sync    <= payload[3];
        end
      end
    end
  end

endmodule

//--- hw/dts_lane_reorder.sv
`timescale 1ns/1ps
`include "dts_rx_config.svh"

module dts_lane_reorder (
  input  logic                   gt_clkout,
  input  logic                   arst_n_i,
  input  dts_rx_pkg::dts_frame_t frames_i   [`DTS_N_LANES],
  input  logic [`DTS_N_LANES-1:0] locked_i,
  input  dts_rx_pkg::lane_sel_t  lane_map_i [`DTS_N_LANES],  // Source per logical lane
  output dts_rx_pkg::dts_frame_t frames_o   [`DTS_N_LANES],
  output logic [`DTS_N_LANES-1:0] locked_o
);

  ///////////////////////////////
  // Crossbar register
  ///////////////////////////////

  // Full crossbar, a source may feed several outputs
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `DTS_N_LANES; i++) begin
        frames_o[i] <= '0;
      end
      locked_o <= '0;
    end else begin
      for (int i = 0; i < `DTS_N_LANES; i++) begin
        frames_o[i] <= frames_i[lane_map_i[i]];
        locked_o[i] <= locked_i[lane_map_i[i]];  // Status follows the data
      end
    end
  end

endmodule

//--- hw/dts_lane_offsetter.sv
`timescale 1ns/1ps
`include "dts_rx_config.svh"

module dts_lane_offsetter (
  input  logic                   gt_clkout,
  input  logic                   arst_n_i,
  input  dts_rx_pkg::dts_frame_t frame_i,
  input  logic                   advance_i,  // Offset down
  input  logic                   delay_i,    // Offset up
  input  logic                   ofs_rst_i,
  output dts_rx_pkg::dts_frame_t frame_o
);

  localparam logic [`DTS_OFS_W-1:0] OFS_MAX = `DTS_OFS_W'(`DTS_MAX_OFFSET);

  // Tap 0 is the live input, taps 1..MAX come from the delay line
  dts_rx_pkg::dts_frame_t taps   [0:`DTS_MAX_OFFSET];
  dts_rx_pkg::dts_frame_t line_q [1:`DTS_MAX_OFFSET];
  logic [`DTS_OFS_W-1:0]  ofs_q;

  ///////////////////////////////
  // Delay line
  ///////////////////////////////

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int k = 1; k <= `DTS_MAX_OFFSET; k++) begin
        line_q[k] <= '0;
      end
    end else begin
      line_q[1] <= frame_i;  // Shifts every cycle
      for (int k = 2; k <= `DTS_MAX_OFFSET; k++) begin
        line_q[k] <= line_q[k-1];
      end
    end
  end

  always_comb begin
    taps[0] = frame_i;
    for (int k = 1; k <= `DTS_MAX_OFFSET; k++) begin
      taps[k] = line_q[k];
    end
  end

  ///////////////////////////////
  // Tap select
  ///////////////////////////////

  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ofs_q <= '0;
    end else if (ofs_rst_i) begin
      ofs_q <= '0;
    end else if (advance_i && !delay_i) begin
      if (ofs_q != '0) ofs_q <= ofs_q - 1'b1;
    end else if (delay_i && !advance_i) begin
      if (ofs_q != OFS_MAX) ofs_q <= ofs_q + 1'b1;
    end
  end

  // A tap change skips or repeats frames once
  always_ff @(posedge gt_clkout or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_o <= '0;
    end else begin
      frame_o <= taps[ofs_q];
    end
  end

endmodule

//--- hw/dts_rx_top.sv
`timescale 1ns/1ps
`include "dts_rx_config.svh"

module dts_rx_top (
  input  logic                    gt_clkout,
  input  logic                    arst_n_i,
  input  dts_rx_pkg::lane_word_t  lane_word_i [`DTS_N_LANES],
  input  logic                    word_vld_i,  // Common to all lanes
  input  dts_rx_pkg::lane_sel_t   lane_map_i  [`DTS_N_LANES],
  input  logic [`DTS_N_LANES-1:0] advance_i,
  input  logic [`DTS_N_LANES-1:0] delay_i,
  input  logic                    ofs_rst_i,
  output logic [`DTS_N_LANES-1:0] slip_o,      // To gearbox
  output dts_rx_pkg::dts_frame_t  frame_o     [`DTS_N_LANES],
  output logic [`DTS_N_LANES-1:0] lane_locked_o
);

  dts_rx_pkg::dts_frame_t  def_frame [`DTS_N_LANES];  // Physical order
  logic [`DTS_N_LANES-1:0] def_locked;
  dts_rx_pkg::dts_frame_t  reo_frame [`DTS_N_LANES];  // Logical order

  ///////////////////////////////
  // Per physical lane
  ///////////////////////////////

  for (genvar i = 0; i < `DTS_N_LANES; i++) begin : g_def
    dts_lane_deformatter u_def (
      .gt_clkout  (gt_clkout),
      .arst_n_i   (arst_n_i),
      .word_i     (lane_word_i[i]),
      .word_vld_i (word_vld_i),
      .slip_o     (slip_o[i]),
      .locked_o   (def_locked[i]),
      .frame_o    (def_frame[i])
    );
  end

  dts_lane_reorder u_reorder (
    .gt_clkout  (gt_clkout),
    .arst_n_i   (arst_n_i),
    .frames_i   (def_frame),
    .locked_i   (def_locked),
    .lane_map_i (lane_map_i),
    .frames_o   (reo_frame),
    .locked_o   (lane_locked_o)  // Not delayed by the offset
  );

  ///////////////////////////////
  // Per logical lane
  ///////////////////////////////

  for (genvar i = 0; i < `DTS_N_LANES; i++) begin : g_ofs
    dts_lane_offsetter u_ofs (
      .gt_clkout (gt_clkout),
      .arst_n_i  (arst_n_i),
      .frame_i   (reo_frame[i]),
      .advance_i (advance_i[i]),
      .delay_i   (delay_i[i]),
      .ofs_rst_i (ofs_rst_i),
      .frame_o   (frame_o[i])
    );
  end

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // Same 1 ns skew as the stimulus
  end

endmodule

//--- tests/tb_dts_rx.sv
`timescale 1ns/1ps
`include "dts_rx_config.svh"

module tb_dts_rx;

  localparam int NL          = `DTS_N_LANES;
  localparam int LOCK_BUDGET = 18 * (`DTS_HOLDOFF + `DTS_LOCK_GOOD + 2);
  localparam int CHECK_LEN   = 140;  // At least two control words per lane
  localparam int MAX_TESTS   = 16;

  logic                    gt_clkout;
  logic                    arst_n;
  dts_rx_pkg::lane_word_t  lane_word [NL];
  logic                    word_vld;
  dts_rx_pkg::lane_sel_t   lane_map [NL];
  logic [NL-1:0]           advance;
  logic [NL-1:0]           delay;
  logic                    ofs_rst;
  logic [NL-1:0]           slip;
  dts_rx_pkg::dts_frame_t  frame [NL];
  logic [NL-1:0]           lane_locked;

  // Golden table, lane 0 is the leftmost hex digit of each field
  string       t_name [MAX_TESTS];
  logic [31:0] t_rot [MAX_TESTS];
  logic [31:0] t_map [MAX_TESTS];
  logic [31:0] t_dly [MAX_TESTS];
  logic [31:0] t_adv [MAX_TESTS];
  logic [31:0] t_src [MAX_TESTS];
  logic [31:0] t_lag [MAX_TESTS];
  logic [31:0] t_cor [MAX_TESTS];

  // Gearbox model
  int          pos [NL];           // Stream index of the next word
  int          rot [NL];           // Bit rotation, 0 is the true boundary
  int          last_slip [NL];
  int          corrupt_left [NL];
  logic [11:0] cnt_start [NL];
  dts_rx_pkg::lane_word_t hist [16][NL];

  int     cyc;
  int     errors;
  int     checks;
  int     n_tests;
  int     limit_cycles;
  bit     lock_seen;
  integer seed;

  tb_clkgen u_clkgen (
    .clk_o   (gt_clkout),
    .rst_n_o (arst_n)
  );

  dts_rx_top uut (
    .gt_clkout     (gt_clkout),
    .arst_n_i      (arst_n),
    .lane_word_i   (lane_word),
    .word_vld_i    (word_vld),
    .lane_map_i    (lane_map),
    .advance_i     (advance),
    .delay_i       (delay),
    .ofs_rst_i     (ofs_rst),
    .slip_o        (slip),
    .frame_o       (frame),
    .lane_locked_o (lane_locked)
  );

  ///////////////////////////////
  // Stream model and helpers
  ///////////////////////////////

  function automatic int digit(input logic [31:0] v, input int l, input int w);
    return int'((v >> (w * (NL - 1 - l))) & ((32'd1 << w) - 1));
  endfunction

  // Data words carry the lane number and a count of data words so far
  function automatic dts_rx_pkg::lane_word_t stream_word(input int lane, input int p);
    logic [11:0] cnt;
    if (p % 64 == 63) begin
      return {`DTS_HDR_CTRL, 12'h000, 4'(1 << ((p / 64) % 4))};  // index first
    end
    cnt = cnt_start[lane] + 12'(p - p / 64);
    return {`DTS_HDR_DATA, 4'(lane), cnt};
  endfunction

  // Header 10 gives data, header 01 gives markers, the rest gives nothing
  function automatic dts_rx_pkg::dts_frame_t expect_frame(input dts_rx_pkg::lane_word_t w);
    dts_rx_pkg::dts_frame_t f;
    f = '0;
    if (w[`DTS_WORD_W-1 -: 2] == `DTS_HDR_DATA) begin
      f.vld  = 1'b1;
      f.data = w[`DTS_PAYLOAD_W-1:0];
    end else if (w[`DTS_WORD_W-1 -: 2] == `DTS_HDR_CTRL) begin
      f.mark = w[3:0];
    end
    return f;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h at cycle %0d", what, got, exp, cyc);
      errors++;
    end
  endtask

  // One clock: react to slips like a gearbox, then present the next words
  task automatic step();
    logic [2*`DTS_WORD_W-1:0] pair;
    dts_rx_pkg::lane_word_t   w;
    @(posedge gt_clkout);
    #1;
    cyc++;
    for (int l = 0; l < NL; l++) begin
      if (slip[l]) begin
        if (lock_seen) begin
          $display("slip_o[%0d] pulsed after every lane had locked, cycle %0d", l, cyc);
          errors++;
        end
        if (cyc - last_slip[l] < `DTS_HOLDOFF + 1) begin
          $display("slip_o[%0d] pulses only %0d cycles apart", l, cyc - last_slip[l]);
          errors++;
        end
        last_slip[l] = cyc;
        rot[l]++;
        if (rot[l] == `DTS_WORD_W) begin  // Full word skipped
          rot[l] = 0;
          pos[l]++;
        end
      end
      pair = {stream_word(l, pos[l]), stream_word(l, pos[l] + 1)};
      w = pair[2*`DTS_WORD_W-1 - rot[l] -: `DTS_WORD_W];
      if (corrupt_left[l] > 0) begin
        w[`DTS_WORD_W-1 -: 2] = 2'b00;
        corrupt_left[l]--;
      end
      lane_word[l] = w;
      hist[cyc % 16][l] = w;
      pos[l]++;
    end
    word_vld = 1'b1;
  endtask

  task automatic wait_locked(input int budget, output bit ok);
    int n;
    n = 0;
    while (lane_locked != '1 && n < budget) begin
      step();
      n++;
    end
    ok = (lane_locked == '1);
  endtask

  task automatic load_golden();
    int          fd;
    int          code;
    string       line;
    string       nm;
    logic [31:0] fld [7];
    n_tests = 0;
    fd = $fopen("tests/dts_rx_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file tests/dts_rx_golden.txt");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h", nm, fld[0], fld[1], fld[2],
                         fld[3], fld[4], fld[5], fld[6]);
          if (code == 8) begin
            t_name[n_tests] = nm;
            t_rot[n_tests]  = fld[0];
            t_map[n_tests]  = fld[1];
            t_dly[n_tests]  = fld[2];
            t_adv[n_tests]  = fld[3];
            t_src[n_tests]  = fld[4];
            t_lag[n_tests]  = fld[5];
            t_cor[n_tests]  = fld[6];
            n_tests++;
          end else begin
            $display("Golden line could not be parsed: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ///////////////////////////////
  // One golden line
  ///////////////////////////////

  task automatic run_test(input int t);
    int                     err0;
    int                     c;
    int                     n;
    bit                     ok;
    dts_rx_pkg::dts_frame_t want;
    err0 = errors;
    for (int l = 0; l < NL; l++) begin
      if (digit(t_rot[t], l, 8) != 0)
        rot[l] = digit(t_rot[t], l, 8);
      lane_map[l] = 2'(digit(t_map[t], l, 4));
    end
    wait_locked(LOCK_BUDGET, ok);
    if (!ok) begin
      $display("Lanes still unlocked after %0d cycles, lane_locked_o = %b",
               LOCK_BUDGET, lane_locked);
      errors++;
    end
    lock_seen = lock_seen | ok;

    ofs_rst = 1'b1;
    step();
    ofs_rst = 1'b0;
    for (int i = 0; i < 16; i++) begin
      for (int l = 0; l < NL; l++)
        delay[l] = (i < digit(t_dly[t], l, 4));
      step();
    end
    delay = '0;
    for (int i = 0; i < 16; i++) begin
      for (int l = 0; l < NL; l++)
        advance[l] = (i < digit(t_adv[t], l, 4));
      step();
    end
    advance = '0;

    c = int'(t_cor[t]);
    if (c < NL) begin  // Header corruption on one physical lane
      corrupt_left[c] = `DTS_LOSS_BAD;
      n = 0;
      while (lane_locked == '1 && n < `DTS_LOSS_BAD + 4) begin
        step();
        n++;
      end
      if (lane_locked == '1) begin
        $display("Lane %0d kept its lock through %0d bad headers", c, `DTS_LOSS_BAD);
        errors++;
      end
      wait_locked(LOCK_BUDGET, ok);
      if (!ok) begin
        $display("Lane %0d did not lock again after losing it", c);
        errors++;
      end
    end

    repeat (24) step();
    repeat (CHECK_LEN) begin
      step();
      for (int j = 0; j < NL; j++) begin
        // 3 cycles of pipeline plus the tap offset
        want = expect_frame(hist[(cyc - 3 - digit(t_lag[t], j, 4)) % 16]
                                [digit(t_src[t], j, 4)]);
        check_val($sformatf("frame_o[%0d]", j), 32'(frame[j]), 32'(want));
      end
      check_val("lane_locked_o", 32'(lane_locked), 32'({NL{1'b1}}));
    end
    $display("test %-10s done, %0d errors", t_name[t], errors - err0);
  endtask

  ///////////////////////////////
  // Main sequence and watchdog
  ///////////////////////////////

  initial begin : main
    seed = 32'ha5d4;
    cyc = 0;
    errors = 0;
    checks = 0;
    lock_seen = 1'b0;
    limit_cycles = 0;
    word_vld = 1'b0;
    advance = '0;
    delay = '0;
    ofs_rst = 1'b0;
    for (int l = 0; l < NL; l++) begin
      lane_word[l] = '0;
      lane_map[l] = 2'(l);
      pos[l] = 0;
      rot[l] = 0;
      last_slip[l] = -1000;
      corrupt_left[l] = 0;
      cnt_start[l] = 12'($random(seed));
    end
    load_golden();
    limit_cycles = n_tests * (LOCK_BUDGET + 300);
    if (n_tests == 0) begin
      $display("No usable test lines in the golden file");
      errors++;
    end else begin
      wait (arst_n === 1'b1);
      for (int t = 0; t < n_tests; t++)
        run_test(t);
    end
    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge gt_clkout);
    $display("Run stopped by the watchdog after %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- tests/dts_rx_golden.txt
# name rotation(2 hex digits per lane) lane_map delay_strobes advance_strobes
#   expected_source expected_lag corrupt_lane (f = none), lane 0 is the leftmost digit
# Nonzero rotations only make sense on the first line, while every lane hunts
lock       0e0f1011  0123  0000  0000  0123  0000  f
permute    00000000  2301  0000  0000  2301  0000  f
duplicate  00000000  1133  0000  0000  1133  0000  f
delay      00000000  0011  3090  0000  0011  3070  f
advance    00000000  0123  5271  2430  0123  3041  f
ofs_reset  00000000  0123  0000  0000  0123  0000  f
relock     00000000  0123  0000  0000  0123  0000  2
relock_map 00000000  3210  0000  0000  3210  0000  1

//--- list.f
+incdir+hw
hw/dts_rx_pkg.sv
hw/dts_lane_deformatter.sv
hw/dts_lane_reorder.sv
hw/dts_lane_offsetter.sv
hw/dts_rx_top.sv
tests/tb_clkgen.sv
tests/tb_dts_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DTS receive testbench with Verilator, run it, check the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_dts_rx \
  -f list.f --Mdir "$BUILD_DIR" -o tb_dts_rx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_dts_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "Failure reported, see $LOG"
  exit 1
fi

exit 0
